// File: design/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath and address width
`define MIPS_DATA_W 32

// Architectural register count
`define MIPS_REG_CNT 32

// Data memory depth in words
`define MIPS_MEM_WORDS 64

// Word index width, taken from address bits 7..2
`define MIPS_MEM_AW 6

// Link target for jal and the branch-and-link forms
`define MIPS_LINK_REG 5'd31

`endif

// File: design/mips_pkg.sv
package mips_pkg;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, // R-type and REGIMM groups
		OP_J       = 6'h02, OP_JAL    = 6'h03,
		OP_BEQ     = 6'h04, OP_BNE    = 6'h05,
		OP_BLEZ    = 6'h06, OP_BGTZ   = 6'h07,
		OP_ADDIU   = 6'h09, OP_SLTI   = 6'h0a,
		OP_SLTIU   = 6'h0b, OP_ANDI   = 6'h0c,
		OP_ORI     = 6'h0d, OP_XORI   = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LB      = 6'h20, OP_LH     = 6'h21, // Loads
		OP_LW      = 6'h23, OP_LBU    = 6'h24,
		OP_LHU     = 6'h25,
		OP_SB      = 6'h28, OP_SH     = 6'h29, // Stores
		OP_SW      = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL  = 6'h00, F_SRL  = 6'h02, F_SRA  = 6'h03,
		F_JR   = 6'h08, F_JALR = 6'h09,
		F_ADDU = 6'h21, F_SUBU = 6'h23,
		F_AND  = 6'h24, F_OR   = 6'h25, F_XOR  = 6'h26, F_NOR = 6'h27,
		F_SLT  = 6'h2a, F_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [4:0] {
		RI_BLTZ   = 5'h00, RI_BGEZ   = 5'h01, // rt field under REGIMM
		RI_BLTZAL = 5'h10, RI_BGEZAL = 5'h11
	} regimm_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
	} branch_e;

	typedef enum logic [2:0] {LD_NONE, LD_B, LD_BU, LD_H, LD_HU, LD_W} load_e;

	typedef enum logic [1:0] {ST_NONE, ST_B, ST_H, ST_W} store_e;

endpackage

// File: design/reg_file.sv
`include "mips_defines.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [4:0]              rd_addr_a,
	input  logic [4:0]              rd_addr_b,
	input  logic                    wr_en,
	input  logic [4:0]              wr_addr,
	input  logic [`MIPS_DATA_W-1:0] wr_data,
	output logic [`MIPS_DATA_W-1:0] rd_data_a,
	output logic [`MIPS_DATA_W-1:0] rd_data_b
);

	logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_CNT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `MIPS_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// r0 is hardwired to zero
	assign rd_data_a = (rd_addr_a == 5'd0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == 5'd0) ? '0 : regs[rd_addr_b];

endmodule

// File: design/main_decode.sv
`include "mips_defines.svh"

module main_decode (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    instr_valid,
	input  logic [31:0]             instr,
	input  logic [`MIPS_DATA_W-1:0] pc,
	output logic                    ex_valid,
	output mips_pkg::alu_op_e       ex_alu_op,
	output logic                    ex_alu_src_imm,
	output logic [`MIPS_DATA_W-1:0] ex_imm,
	output logic [4:0]              ex_shamt,
	output logic [4:0]              ex_rs,
	output logic [4:0]              ex_rt,
	output logic [4:0]              ex_dest,
	output logic                    ex_regwrite,
	output mips_pkg::branch_e       ex_branch,
	output logic                    ex_jump,
	output logic                    ex_jump_reg,
	output logic                    ex_link,
	output mips_pkg::load_e         ex_load,
	output mips_pkg::store_e        ex_store,
	output logic                    ex_illegal,
	output logic [`MIPS_DATA_W-1:0] ex_pc
);

	mips_pkg::opcode_e op;
	mips_pkg::funct_e  fn;
	mips_pkg::regimm_e ri;
	mips_pkg::alu_op_e dec_alu_op;
	mips_pkg::branch_e dec_branch;
	mips_pkg::load_e   dec_load;
	mips_pkg::store_e  dec_store;
	logic              dec_src_imm, dec_zext, dec_wr, dec_jump, dec_jump_reg;
	logic              dec_link, dec_bad;
	logic [4:0]        dec_dest;
	logic [`MIPS_DATA_W-1:0] dec_imm;

	assign op = mips_pkg::opcode_e'(instr[31:26]);
	assign fn = mips_pkg::funct_e'(instr[5:0]);
	assign ri = mips_pkg::regimm_e'(instr[20:16]);

	always_comb begin
		dec_alu_op   = mips_pkg::ALU_ADD;
		dec_branch   = mips_pkg::BR_NONE;
		dec_load     = mips_pkg::LD_NONE;
		dec_store    = mips_pkg::ST_NONE;
		dec_src_imm  = 1'b1; // Immediate forms are the common case
		dec_zext     = 1'b0;
		dec_wr       = 1'b1;
		dec_jump     = 1'b0;
		dec_jump_reg = 1'b0;
		dec_link     = 1'b0;
		dec_bad      = 1'b0;
		dec_dest     = instr[20:16]; // rt by default
		case (op)
			mips_pkg::OP_SPECIAL: begin
				dec_src_imm = 1'b0;
				dec_dest    = instr[15:11]; // rd
				case (fn)
					mips_pkg::F_ADDU: dec_alu_op = mips_pkg::ALU_ADD;
					mips_pkg::F_SUBU: dec_alu_op = mips_pkg::ALU_SUB;
					mips_pkg::F_AND:  dec_alu_op = mips_pkg::ALU_AND;
					mips_pkg::F_OR:   dec_alu_op = mips_pkg::ALU_OR;
					mips_pkg::F_XOR:  dec_alu_op = mips_pkg::ALU_XOR;
					mips_pkg::F_NOR:  dec_alu_op = mips_pkg::ALU_NOR;
					mips_pkg::F_SLT:  dec_alu_op = mips_pkg::ALU_SLT;
					mips_pkg::F_SLTU: dec_alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::F_SLL:  dec_alu_op = mips_pkg::ALU_SLL;
					mips_pkg::F_SRL:  dec_alu_op = mips_pkg::ALU_SRL;
					mips_pkg::F_SRA:  dec_alu_op = mips_pkg::ALU_SRA;
					mips_pkg::F_JR: begin
						dec_wr       = 1'b0;
						dec_jump_reg = 1'b1;
					end
					mips_pkg::F_JALR: begin
						dec_jump_reg = 1'b1; // Link lands in rd
						dec_link     = 1'b1;
					end
					default: dec_bad = 1'b1;
				endcase
			end
			mips_pkg::OP_REGIMM: begin
				dec_wr   = ri[4]; // Bit 4 of rt marks the linking forms
				dec_link = ri[4];
				dec_dest = `MIPS_LINK_REG;
				case (ri)
					mips_pkg::RI_BLTZ, mips_pkg::RI_BLTZAL: dec_branch = mips_pkg::BR_LTZ;
					mips_pkg::RI_BGEZ, mips_pkg::RI_BGEZAL: dec_branch = mips_pkg::BR_GEZ;
					default: dec_bad = 1'b1;
				endcase
			end
			mips_pkg::OP_J:     dec_wr = 1'b0;
			mips_pkg::OP_JAL:   dec_dest = `MIPS_LINK_REG;
			mips_pkg::OP_BEQ:   dec_branch = mips_pkg::BR_EQ;
			mips_pkg::OP_BNE:   dec_branch = mips_pkg::BR_NE;
			mips_pkg::OP_BLEZ:  dec_branch = mips_pkg::BR_LEZ;
			mips_pkg::OP_BGTZ:  dec_branch = mips_pkg::BR_GTZ;
			mips_pkg::OP_ADDIU: dec_alu_op = mips_pkg::ALU_ADD;
			mips_pkg::OP_SLTI:  dec_alu_op = mips_pkg::ALU_SLT;
			mips_pkg::OP_SLTIU: dec_alu_op = mips_pkg::ALU_SLTU;
			mips_pkg::OP_LUI:   dec_alu_op = mips_pkg::ALU_LUI;
			mips_pkg::OP_ANDI: begin
				dec_alu_op = mips_pkg::ALU_AND;
				dec_zext   = 1'b1;
			end
			mips_pkg::OP_ORI: begin
				dec_alu_op = mips_pkg::ALU_OR;
				dec_zext   = 1'b1;
			end
			mips_pkg::OP_XORI: begin
				dec_alu_op = mips_pkg::ALU_XOR;
				dec_zext   = 1'b1;
			end
			mips_pkg::OP_LB:  dec_load = mips_pkg::LD_B;
			mips_pkg::OP_LBU: dec_load = mips_pkg::LD_BU;
			mips_pkg::OP_LH:  dec_load = mips_pkg::LD_H;
			mips_pkg::OP_LHU: dec_load = mips_pkg::LD_HU;
			mips_pkg::OP_LW:  dec_load = mips_pkg::LD_W;
			mips_pkg::OP_SB:  dec_store = mips_pkg::ST_B;
			mips_pkg::OP_SH:  dec_store = mips_pkg::ST_H;
			mips_pkg::OP_SW:  dec_store = mips_pkg::ST_W;
			default: dec_bad = 1'b1;
		endcase
		if (op == mips_pkg::OP_BEQ || op == mips_pkg::OP_BNE || op == mips_pkg::OP_BLEZ ||
				op == mips_pkg::OP_BGTZ || op == mips_pkg::OP_J || dec_store != mips_pkg::ST_NONE) begin
			dec_wr = 1'b0; // Plain branches, j and stores write nothing
		end
		if (op == mips_pkg::OP_J || op == mips_pkg::OP_JAL) begin
			dec_jump = 1'b1;
			dec_link = (op == mips_pkg::OP_JAL);
		end
		if (dec_bad) begin // Illegal retires with no side effects
			dec_wr       = 1'b0;
			dec_branch   = mips_pkg::BR_NONE;
			dec_jump     = 1'b0;
			dec_jump_reg = 1'b0;
			dec_link     = 1'b0;
			dec_load     = mips_pkg::LD_NONE;
			dec_store    = mips_pkg::ST_NONE;
		end
	end

	always_comb begin
		if (dec_jump)
			dec_imm = {6'b0, instr[25:0]}; // Jump index
		else if (dec_zext)
			dec_imm = {16'b0, instr[15:0]};
		else
			dec_imm = {{16{instr[15]}}, instr[15:0]};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid    <= 1'b0;
			ex_regwrite <= 1'b0;
			ex_branch   <= mips_pkg::BR_NONE;
			ex_jump     <= 1'b0;
			ex_jump_reg <= 1'b0;
			ex_link     <= 1'b0;
			ex_load     <= mips_pkg::LD_NONE;
			ex_store    <= mips_pkg::ST_NONE;
			ex_illegal  <= 1'b0;
		end else begin
			ex_valid <= instr_valid;
			if (instr_valid) begin
				ex_regwrite <= dec_wr && (dec_dest != 5'd0); // r0 writes dropped here
				ex_branch   <= dec_branch;
				ex_jump     <= dec_jump;
				ex_jump_reg <= dec_jump_reg;
				ex_link     <= dec_link;
				ex_load     <= dec_load;
				ex_store    <= dec_store;
				ex_illegal  <= dec_bad;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin // Payload only
			ex_alu_op      <= dec_alu_op;
			ex_alu_src_imm <= dec_src_imm;
			ex_imm         <= dec_imm;
			ex_shamt       <= instr[10:6];
			ex_rs          <= instr[25:21];
			ex_rt          <= instr[20:16];
			ex_dest        <= dec_dest;
			ex_pc          <= pc;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		ex_valid && ex_store != mips_pkg::ST_NONE |-> !ex_regwrite);

endmodule

// File: design/execute_stage.sv
`include "mips_defines.svh"

module execute_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    ex_valid,
	input  mips_pkg::alu_op_e       ex_alu_op,
	input  logic                    ex_alu_src_imm,
	input  logic [`MIPS_DATA_W-1:0] ex_imm,
	input  logic [4:0]              ex_shamt,
	input  logic [4:0]              ex_rs,
	input  logic [4:0]              ex_rt,
	input  logic [4:0]              ex_dest,
	input  logic                    ex_regwrite,
	input  mips_pkg::branch_e       ex_branch,
	input  logic                    ex_jump,
	input  logic                    ex_jump_reg,
	input  logic                    ex_link,
	input  mips_pkg::load_e         ex_load,
	input  mips_pkg::store_e        ex_store,
	input  logic                    ex_illegal,
	input  logic [`MIPS_DATA_W-1:0] ex_pc,
	input  logic [`MIPS_DATA_W-1:0] rd_data_a,
	input  logic [`MIPS_DATA_W-1:0] rd_data_b,
	input  logic                    fwd_en,
	input  logic [4:0]              fwd_reg,
	input  logic [`MIPS_DATA_W-1:0] fwd_data,
	output logic [4:0]              rd_addr_a,
	output logic [4:0]              rd_addr_b,
	output logic                    rs_valid,
	output logic [`MIPS_DATA_W-1:0] rs_result,
	output logic [`MIPS_DATA_W-1:0] rs_store_data,
	output logic [4:0]              rs_dest,
	output logic                    rs_regwrite,
	output mips_pkg::load_e         rs_load,
	output mips_pkg::store_e        rs_store,
	output logic                    rs_redirect,
	output logic [`MIPS_DATA_W-1:0] rs_target,
	output logic                    rs_illegal
);

	logic [`MIPS_DATA_W-1:0] op_a, op_b, alu_b, alu_y, pc_plus4, pc_plus8, target;
	logic                    taken, redirect;

	assign rd_addr_a = ex_rs;
	assign rd_addr_b = ex_rt;

	// Result stage value wins over the not yet written register
	assign op_a  = (fwd_en && fwd_reg == ex_rs && ex_rs != 5'd0) ? fwd_data : rd_data_a;
	assign op_b  = (fwd_en && fwd_reg == ex_rt && ex_rt != 5'd0) ? fwd_data : rd_data_b;
	assign alu_b = ex_alu_src_imm ? ex_imm : op_b;

	always_comb begin
		case (ex_alu_op)
			mips_pkg::ALU_ADD:  alu_y = op_a + alu_b; // Also load/store address
			mips_pkg::ALU_SUB:  alu_y = op_a - alu_b;
			mips_pkg::ALU_AND:  alu_y = op_a & alu_b;
			mips_pkg::ALU_OR:   alu_y = op_a | alu_b;
			mips_pkg::ALU_XOR:  alu_y = op_a ^ alu_b;
			mips_pkg::ALU_NOR:  alu_y = ~(op_a | alu_b);
			mips_pkg::ALU_SLT:  alu_y = {31'b0, $signed(op_a) < $signed(alu_b)};
			mips_pkg::ALU_SLTU: alu_y = {31'b0, op_a < alu_b};
			mips_pkg::ALU_SLL:  alu_y = alu_b << ex_shamt;
			mips_pkg::ALU_SRL:  alu_y = alu_b >> ex_shamt;
			mips_pkg::ALU_SRA:  alu_y = $signed(alu_b) >>> ex_shamt;
			mips_pkg::ALU_LUI:  alu_y = {alu_b[15:0], 16'b0};
			default:            alu_y = '0;
		endcase
	end

	always_comb begin
		case (ex_branch)
			mips_pkg::BR_EQ:  taken = (op_a == op_b);
			mips_pkg::BR_NE:  taken = (op_a != op_b);
			mips_pkg::BR_LEZ: taken = op_a[31] || (op_a == '0);
			mips_pkg::BR_GTZ: taken = !op_a[31] && (op_a != '0);
			mips_pkg::BR_LTZ: taken = op_a[31];
			mips_pkg::BR_GEZ: taken = !op_a[31];
			default:          taken = 1'b0;
		endcase
	end

	assign pc_plus4 = ex_pc + 32'd4;
	assign pc_plus8 = ex_pc + 32'd8; // Link value
	assign redirect = ex_jump || ex_jump_reg || taken;

	always_comb begin
		if (ex_jump_reg)
			target = op_a;
		else if (ex_jump)
			target = {pc_plus4[31:28], ex_imm[25:0], 2'b00}; // Region jump
		else
			target = pc_plus4 + {ex_imm[29:0], 2'b00};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rs_valid    <= 1'b0;
			rs_regwrite <= 1'b0;
			rs_load     <= mips_pkg::LD_NONE;
			rs_store    <= mips_pkg::ST_NONE;
			rs_redirect <= 1'b0;
			rs_illegal  <= 1'b0;
		end else begin
			rs_valid <= ex_valid;
			if (ex_valid) begin
				rs_regwrite <= ex_regwrite;
				rs_load     <= ex_load;
				rs_store    <= ex_store;
				rs_redirect <= redirect;
				rs_illegal  <= ex_illegal;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			rs_result     <= ex_link ? pc_plus8 : alu_y;
			rs_store_data <= op_b;
			rs_dest       <= ex_dest;
			rs_target     <= target;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		ex_valid |-> !(ex_jump && ex_branch != mips_pkg::BR_NONE));

endmodule

// File: design/result_stage.sv
`include "mips_defines.svh"

module result_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    rs_valid,
	input  logic [`MIPS_DATA_W-1:0] rs_result,
	input  logic [`MIPS_DATA_W-1:0] rs_store_data,
	input  logic [4:0]              rs_dest,
	input  logic                    rs_regwrite,
	input  mips_pkg::load_e         rs_load,
	input  mips_pkg::store_e        rs_store,
	input  logic                    rs_redirect,
	input  logic [`MIPS_DATA_W-1:0] rs_target,
	input  logic                    rs_illegal,
	output logic                    wr_en,
	output logic [4:0]              wr_addr,
	output logic [`MIPS_DATA_W-1:0] wr_data,
	output logic                    fwd_en,
	output logic [4:0]              fwd_reg,
	output logic [`MIPS_DATA_W-1:0] fwd_data,
	output logic                    retire_valid,
	output logic                    wb_en,
	output logic [4:0]              wb_reg,
	output logic [`MIPS_DATA_W-1:0] wb_data,
	output logic                    redirect,
	output logic [`MIPS_DATA_W-1:0] redirect_target,
	output logic                    illegal
);

	logic [`MIPS_DATA_W-1:0] mem [`MIPS_MEM_WORDS];
	logic [`MIPS_MEM_AW-1:0] word_idx;
	logic [`MIPS_DATA_W-1:0] mem_word, load_data;
	logic [7:0]              ld_byte;
	logic [15:0]             ld_half;

	assign word_idx = rs_result[`MIPS_MEM_AW+1:2];
	assign mem_word = mem[word_idx];

	// Little-endian lane picks
	assign ld_byte = mem_word[{rs_result[1:0], 3'b000} +: 8];
	assign ld_half = mem_word[{rs_result[1], 4'b0000} +: 16];

	always_comb begin
		case (rs_load)
			mips_pkg::LD_B:  load_data = {{24{ld_byte[7]}}, ld_byte};
			mips_pkg::LD_BU: load_data = {24'b0, ld_byte};
			mips_pkg::LD_H:  load_data = {{16{ld_half[15]}}, ld_half};
			mips_pkg::LD_HU: load_data = {16'b0, ld_half};
			default:         load_data = mem_word;
		endcase
	end

	// Store lanes merged into the addressed word
	always_ff @(posedge clk) begin
		if (rs_valid) begin
			case (rs_store)
				mips_pkg::ST_B: mem[word_idx][{rs_result[1:0], 3'b000} +: 8] <= rs_store_data[7:0];
				mips_pkg::ST_H: mem[word_idx][{rs_result[1], 4'b0000} +: 16] <= rs_store_data[15:0];
				mips_pkg::ST_W: mem[word_idx] <= rs_store_data;
				default: ;
			endcase
		end
	end

	assign wr_en   = rs_valid && rs_regwrite;
	assign wr_addr = rs_dest;
	assign wr_data = (rs_load != mips_pkg::LD_NONE) ? load_data : rs_result;

	// Same value feeds execute one instruction behind
	assign fwd_en   = wr_en;
	assign fwd_reg  = wr_addr;
	assign fwd_data = wr_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retire_valid <= 1'b0;
			wb_en        <= 1'b0;
			redirect     <= 1'b0;
			illegal      <= 1'b0;
		end else begin
			retire_valid <= rs_valid;
			wb_en        <= wr_en;
			redirect     <= rs_valid && rs_redirect;
			illegal      <= rs_valid && rs_illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (rs_valid) begin
			wb_reg          <= rs_dest;
			wb_data         <= wr_data;
			redirect_target <= rs_target;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) wb_en |-> wb_reg != 5'd0);

	// Checked one edge later at the retire ports
	assert property (@(posedge clk) disable iff (!arst_n)
		rs_valid && rs_store != mips_pkg::ST_NONE |=> !wb_en);

endmodule

// File: design/mips_exec_top.sv
`include "mips_defines.svh"

module mips_exec_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    instr_valid,
	input  logic [31:0]             instr,
	input  logic [`MIPS_DATA_W-1:0] pc,
	output logic                    retire_valid,
	output logic                    wb_en,
	output logic [4:0]              wb_reg,
	output logic [`MIPS_DATA_W-1:0] wb_data,
	output logic                    redirect,
	output logic [`MIPS_DATA_W-1:0] redirect_target,
	output logic                    illegal
);

	// Decode to execute
	logic                    ex_valid, ex_alu_src_imm, ex_regwrite, ex_jump, ex_jump_reg;
	logic                    ex_link, ex_illegal;
	mips_pkg::alu_op_e       ex_alu_op;
	mips_pkg::branch_e       ex_branch;
	mips_pkg::load_e         ex_load;
	mips_pkg::store_e        ex_store;
	logic [`MIPS_DATA_W-1:0] ex_imm, ex_pc;
	logic [4:0]              ex_shamt, ex_rs, ex_rt, ex_dest;

	// Execute to result
	logic                    rs_valid, rs_regwrite, rs_redirect, rs_illegal;
	logic [`MIPS_DATA_W-1:0] rs_result, rs_store_data, rs_target;
	logic [4:0]              rs_dest;
	mips_pkg::load_e         rs_load;
	mips_pkg::store_e        rs_store;

	// Register file and forwarding
	logic [4:0]              rd_addr_a, rd_addr_b, wr_addr, fwd_reg;
	logic [`MIPS_DATA_W-1:0] rd_data_a, rd_data_b, wr_data, fwd_data;
	logic                    wr_en, fwd_en;

	main_decode decode_i (.*);

	execute_stage execute_i (.*);

	result_stage result_i (.*);

	reg_file reg_file_i (.*);

endmodule

// File: test/tb_mips_exec.sv
`include "mips_defines.svh"

module tb_mips_exec;

	localparam int RST_CYCLES = 16;
	localparam int IDLE_CHECK = 4; // Quiet cycles after reset
	localparam int LATENCY    = 3;
	localparam int N_FILL     = 2 * `MIPS_MEM_WORDS; // addiu plus sw per word
	localparam int N_ALU      = 200;
	localparam int N_FWD      = 10 + 80;
	localparam int N_MEM      = 120;
	localparam int N_BR       = 2 + 120;
	localparam int N_ZERO     = 9;
	localparam int N_TESTS    = 7;
	localparam int N_INSTR    = N_FILL + N_ALU + N_FWD + N_MEM + N_BR + N_ZERO;
	// Each test drains the pipe before the next one starts
	localparam int TIMEOUT    = RST_CYCLES + IDLE_CHECK + N_INSTR + N_TESTS * (LATENCY + 2) + 20;

	typedef struct packed {
		logic        wb_en;
		logic [4:0]  wb_reg;
		logic [31:0] wb_data;
		logic        redirect;
		logic [31:0] target;
		logic        illegal;
		logic [31:0] pc;
		int          due; // Cycle count at which retire is seen
		int          test;
	} expect_t;

	logic                    clk, arst_n, instr_valid;
	logic [31:0]             instr;
	logic [`MIPS_DATA_W-1:0] pc;
	logic                    retire_valid, wb_en, redirect, illegal;
	logic [4:0]              wb_reg;
	logic [`MIPS_DATA_W-1:0] wb_data, redirect_target;

	logic [15:0]             lfsr;
	logic [`MIPS_DATA_W-1:0] mregs [`MIPS_REG_CNT]; // Model register file
	logic [`MIPS_DATA_W-1:0] mmem [`MIPS_MEM_WORDS]; // Model data memory
	logic [`MIPS_DATA_W-1:0] next_pc;
	expect_t                 expq [$];
	int                      cyc = 0;
	int                      cur_test = 0;
	int                      fails [N_TESTS] = '{default: 0};
	string                   test_names [N_TESTS] = '{"reset_idle", "mem_fill", "alu_random",
		"fwd_chain", "mem_widths", "branch_jump", "r0_illegal"};

	mips_exec_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr); // One step per bit
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// ISA behaviour of one instruction applied to the model state in program order
	function automatic expect_t model_step(input logic [31:0] ins, input logic [31:0] ipc);
		expect_t     e;
		logic [4:0]  rs, rt, rd, sh, dst;
		logic [31:0] a, b, simm, zimm, addr, w, pc4, val, bsh, hsh;
		logic        wr, taken;
		int          sa8, sa16;
		rs   = ins[25:21];
		rt   = ins[20:16];
		rd   = ins[15:11];
		sh   = ins[10:6];
		a    = mregs[rs];
		b    = mregs[rt];
		simm = {{16{ins[15]}}, ins[15:0]};
		zimm = {16'b0, ins[15:0]};
		addr = a + simm;
		w    = mmem[addr[7:2]];
		sa8  = 8 * addr[1:0];
		sa16 = 16 * addr[1];
		bsh  = w >> sa8; // Addressed byte in bits 7..0
		hsh  = w >> sa16;
		pc4  = ipc + 4;
		e        = '0;
		e.pc     = ipc;
		e.target = pc4 + (simm << 2); // Branch form unless a jump overrides it
		dst   = rt;
		val   = '0;
		wr    = 1'b1;
		taken = 1'b0;
		case (ins[31:26])
			mips_pkg::OP_SPECIAL: begin
				dst = rd;
				case (ins[5:0])
					mips_pkg::F_ADDU: val = a + b;
					mips_pkg::F_SUBU: val = a - b;
					mips_pkg::F_AND:  val = a & b;
					mips_pkg::F_OR:   val = a | b;
					mips_pkg::F_XOR:  val = a ^ b;
					mips_pkg::F_NOR:  val = ~(a | b);
					mips_pkg::F_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mips_pkg::F_SLTU: val = (a < b) ? 32'd1 : 32'd0;
					mips_pkg::F_SLL:  val = b << sh;
					mips_pkg::F_SRL:  val = b >> sh;
					mips_pkg::F_SRA:  val = $signed(b) >>> sh;
					mips_pkg::F_JR: begin
						wr       = 1'b0;
						taken    = 1'b1;
						e.target = a;
					end
					mips_pkg::F_JALR: begin
						val      = ipc + 8;
						taken    = 1'b1;
						e.target = a;
					end
					default: e.illegal = 1'b1;
				endcase
			end
			mips_pkg::OP_REGIMM: begin
				dst = `MIPS_LINK_REG;
				val = ipc + 8; // Links whether taken or not
				wr  = rt[4];
				case (rt)
					5'h00, 5'h10: taken = $signed(a) < 0;
					5'h01, 5'h11: taken = $signed(a) >= 0;
					default:      e.illegal = 1'b1;
				endcase
			end
			mips_pkg::OP_J, mips_pkg::OP_JAL: begin
				taken    = 1'b1;
				e.target = {pc4[31:28], ins[25:0], 2'b00};
				dst      = `MIPS_LINK_REG;
				val      = ipc + 8;
				wr       = ins[26]; // Only jal links
			end
			mips_pkg::OP_BEQ:   taken = (a == b);
			mips_pkg::OP_BNE:   taken = (a != b);
			mips_pkg::OP_BLEZ:  taken = $signed(a) <= 0;
			mips_pkg::OP_BGTZ:  taken = $signed(a) > 0;
			mips_pkg::OP_ADDIU: val = a + simm;
			mips_pkg::OP_SLTI:  val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			mips_pkg::OP_SLTIU: val = (a < simm) ? 32'd1 : 32'd0;
			mips_pkg::OP_ANDI:  val = a & zimm;
			mips_pkg::OP_ORI:   val = a | zimm;
			mips_pkg::OP_XORI:  val = a ^ zimm;
			mips_pkg::OP_LUI:   val = {ins[15:0], 16'b0};
			mips_pkg::OP_LB:    val = {{24{bsh[7]}}, bsh[7:0]};
			mips_pkg::OP_LBU:   val = {24'b0, bsh[7:0]};
			mips_pkg::OP_LH:    val = {{16{hsh[15]}}, hsh[15:0]};
			mips_pkg::OP_LHU:   val = {16'b0, hsh[15:0]};
			mips_pkg::OP_LW:    val = w;
			mips_pkg::OP_SB:    mmem[addr[7:2]] = (w & ~(32'hff << sa8)) |
				((b & 32'hff) << sa8);
			mips_pkg::OP_SH:    mmem[addr[7:2]] = (w & ~(32'hffff << sa16)) |
				((b & 32'hffff) << sa16);
			mips_pkg::OP_SW:    mmem[addr[7:2]] = b;
			default:            e.illegal = 1'b1;
		endcase
		if (e.illegal || ins[31:26] inside {mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ,
				mips_pkg::OP_BGTZ, mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW}) begin
			wr    = 1'b0; // No register result
			taken = taken && !e.illegal;
		end
		e.redirect = taken;
		if (wr && dst != 5'd0) begin
			mregs[dst] = val;
			e.wb_en    = 1'b1;
			e.wb_reg   = dst;
			e.wb_data  = val;
		end
		return e;
	endfunction

	function automatic logic [31:0] gen_alu();
		logic [4:0]  rs, rt, rd, sh;
		logic [15:0] imm;
		logic [3:0]  pick;
		rs   = rand_bits(3); // r0..r7 so dependencies are frequent
		rt   = rand_bits(3);
		rd   = rand_bits(3);
		sh   = rand_bits(5);
		imm  = rand_bits(16);
		pick = rand_bits(4);
		case (pick)
			4'd0:  return enc_r(mips_pkg::F_ADDU, rs, rt, rd, 5'd0);
			4'd1:  return enc_r(mips_pkg::F_SUBU, rs, rt, rd, 5'd0);
			4'd2:  return enc_r(mips_pkg::F_AND, rs, rt, rd, 5'd0);
			4'd3:  return enc_r(mips_pkg::F_OR, rs, rt, rd, 5'd0);
			4'd4:  return enc_r(mips_pkg::F_XOR, rs, rt, rd, 5'd0);
			4'd5:  return enc_r(mips_pkg::F_NOR, rs, rt, rd, 5'd0);
			4'd6:  return enc_r(mips_pkg::F_SLT, rs, rt, rd, 5'd0);
			4'd7:  return enc_r(mips_pkg::F_SLTU, rs, rt, rd, 5'd0);
			4'd8:  return enc_r(mips_pkg::F_SLL, 5'd0, rt, rd, sh);
			4'd9:  return enc_r(mips_pkg::F_SRL, 5'd0, rt, rd, sh);
			4'd10: return enc_r(mips_pkg::F_SRA, 5'd0, rt, rd, sh);
			4'd11: return enc_i(mips_pkg::OP_ADDIU, rs, rd, imm);
			4'd12: return enc_i(mips_pkg::OP_SLTI, rs, rd, imm);
			4'd13: return enc_i(mips_pkg::OP_SLTIU, rs, rd, imm);
			4'd14: return enc_i(mips_pkg::OP_LUI, 5'd0, rd, imm);
			default: begin
				if (imm[1:0] == 2'd0)
					return enc_i(mips_pkg::OP_ANDI, rs, rd, imm);
				else if (imm[1:0] == 2'd1)
					return enc_i(mips_pkg::OP_ORI, rs, rd, imm);
				else
					return enc_i(mips_pkg::OP_XORI, rs, rd, imm);
			end
		endcase
	endfunction

	// Base r0 so the offset alone is the address inside the memory
	function automatic logic [31:0] gen_mem();
		logic [2:0] pick;
		logic [4:0] rt;
		logic [5:0] word, op;
		logic [1:0] lane;
		pick = rand_bits(3);
		rt   = rand_bits(3);
		word = rand_bits(6);
		lane = rand_bits(2);
		case (pick)
			3'd0: op = mips_pkg::OP_LB;
			3'd1: op = mips_pkg::OP_LBU;
			3'd2: op = mips_pkg::OP_LH;
			3'd3: op = mips_pkg::OP_LHU;
			3'd4: op = mips_pkg::OP_LW;
			3'd5: op = mips_pkg::OP_SB;
			3'd6: op = mips_pkg::OP_SH;
			default: op = mips_pkg::OP_SW;
		endcase
		if (pick inside {3'd2, 3'd3, 3'd6})
			lane[0] = 1'b0; // Halfword aligned
		if (pick inside {3'd4, 3'd7})
			lane = 2'b00;
		return enc_i(op, 5'd0, rt, {8'b0, word, lane});
	endfunction

	function automatic logic [31:0] gen_branch();
		logic [4:0]  rs, rt, rd;
		logic [15:0] off;
		logic [25:0] idx;
		logic [3:0]  pick;
		rs   = rand_bits(3);
		rt   = rand_bits(3);
		rd   = rand_bits(3);
		off  = rand_bits(16);
		idx  = rand_bits(26);
		pick = rand_bits(4);
		case (pick)
			4'd0:  return enc_i(mips_pkg::OP_BEQ, rs, rt, off);
			4'd1:  return enc_i(mips_pkg::OP_BNE, rs, rt, off);
			4'd2:  return enc_i(mips_pkg::OP_BLEZ, rs, 5'd0, off);
			4'd3:  return enc_i(mips_pkg::OP_BGTZ, rs, 5'd0, off);
			4'd4:  return enc_i(mips_pkg::OP_REGIMM, rs, mips_pkg::RI_BLTZ, off);
			4'd5:  return enc_i(mips_pkg::OP_REGIMM, rs, mips_pkg::RI_BGEZ, off);
			4'd6:  return enc_i(mips_pkg::OP_REGIMM, rs, mips_pkg::RI_BLTZAL, off);
			4'd7:  return enc_i(mips_pkg::OP_REGIMM, rs, mips_pkg::RI_BGEZAL, off);
			4'd8:  return {6'(mips_pkg::OP_J), idx};
			4'd9:  return {6'(mips_pkg::OP_JAL), idx};
			4'd10: return enc_r(mips_pkg::F_JR, rs, 5'd0, 5'd0, 5'd0);
			4'd11: return enc_r(mips_pkg::F_JALR, rs, 5'd0, rd, 5'd0);
			default: return gen_alu(); // Keeps register signs moving
		endcase
	endfunction

	task automatic issue(input logic [31:0] ins);
		expect_t e;
		@(posedge clk);
		e      = model_step(ins, next_pc);
		e.due  = cyc + 4; // Sampled at the next edge and seen three edges later
		e.test = cur_test;
		expq.push_back(e);
		instr_valid <= 1'b1;
		instr       <= ins;
		pc          <= next_pc;
		next_pc = next_pc + 4;
	endtask

	task automatic check_field(input int t, input string what, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		assert (act_v === exp_v) else begin
			$display("[FAIL] %s %s expected %h actual %h", test_names[t], what, exp_v, act_v);
			fails[t]++;
		end
	endtask

	task automatic report_test();
		$display("Test %-11s %s, %0d errors", test_names[cur_test],
			(fails[cur_test] == 0) ? "passed" : "failed", fails[cur_test]);
	endtask

	task automatic finish_test();
		@(posedge clk);
		instr_valid <= 1'b0;
		while (expq.size() != 0)
			@(posedge clk);
		report_test();
	endtask

	// Retire ports are stable at the falling edge
	always @(negedge clk) begin
		expect_t e;
		if (arst_n === 1'b1) begin
			if (retire_valid) begin
				assert (expq.size() != 0) else begin
					$display("Test %s: retire at cycle %0d with no instruction in flight",
						test_names[cur_test], cyc);
					fails[cur_test]++;
				end
				if (expq.size() != 0) begin
					e = expq.pop_front();
					check_field(e.test, "retire cycle", e.due, cyc);
					check_field(e.test, "wb_en", e.wb_en, wb_en);
					check_field(e.test, "illegal", e.illegal, illegal);
					check_field(e.test, "redirect", e.redirect, redirect);
					if (e.wb_en) begin
						check_field(e.test, "wb_reg", e.wb_reg, wb_reg);
						check_field(e.test, "wb_data", e.wb_data, wb_data);
					end
					if (e.redirect)
						check_field(e.test, "redirect_target", e.target, redirect_target);
				end
			end else if (expq.size() != 0) begin
				e = expq[0];
				assert (e.due > cyc) else begin
					$display("Test %s: instruction at pc %h never retired",
						test_names[e.test], e.pc);
					fails[e.test]++;
					void'(expq.pop_front());
				end
			end
		end
	end

	initial begin : watchdog
		wait (cyc >= TIMEOUT);
		$display("Run stopped after %0d cycles with %0d instructions outstanding",
			cyc, expq.size());
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int npass;
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		lfsr        = 16'd52112;
		next_pc     = 32'h0000_1000;
		npass       = 0;
		for (int i = 0; i < `MIPS_REG_CNT; i++)
			mregs[i] = '0;
		for (int i = 0; i < `MIPS_MEM_WORDS; i++)
			mmem[i] = '0;
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		cur_test = 0; // Nothing retires before the first instruction
		repeat (IDLE_CHECK) begin
			@(negedge clk);
			check_field(0, "retire_valid", 0, retire_valid);
			check_field(0, "wb_en", 0, wb_en);
			check_field(0, "redirect", 0, redirect);
			check_field(0, "illegal", 0, illegal);
		end
		report_test();

		cur_test = 1; // Pattern from the whole word index
		for (int i = 0; i < `MIPS_MEM_WORDS; i++) begin
			issue(enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'd1, {i[5:0], ~i[5:0], i[5:2]}));
			issue(enc_i(mips_pkg::OP_SW, 5'd0, 5'd1, 16'(i * 4)));
		end
		finish_test();

		cur_test = 2;
		repeat (N_ALU) issue(gen_alu());
		finish_test();

		cur_test = 3; // Distance one and two then a load and its user
		issue(enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h9234));
		issue(enc_r(mips_pkg::F_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
		issue(enc_r(mips_pkg::F_SUBU, 5'd2, 5'd1, 5'd3, 5'd0));
		issue(enc_i(mips_pkg::OP_SW, 5'd0, 5'd3, 16'h0010));
		issue(enc_i(mips_pkg::OP_LW, 5'd0, 5'd4, 16'h0010));
		issue(enc_r(mips_pkg::F_ADDU, 5'd4, 5'd4, 5'd5, 5'd0));
		issue(enc_r(mips_pkg::F_XOR, 5'd5, 5'd4, 5'd6, 5'd0));
		issue(enc_i(mips_pkg::OP_LH, 5'd0, 5'd7, 16'h0012));
		issue(enc_r(mips_pkg::F_SLL, 5'd0, 5'd7, 5'd7, 5'd3));
		issue(enc_r(mips_pkg::F_OR, 5'd7, 5'd7, 5'd1, 5'd0));
		repeat (N_FWD - 10) issue(rand_bits(1) ? gen_mem() : gen_alu());
		finish_test();

		cur_test = 4;
		repeat (N_MEM) issue(gen_mem());
		finish_test();

		cur_test = 5;
		issue(enc_i(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hfff0)); // Always taken
		issue(enc_i(mips_pkg::OP_BNE, 5'd0, 5'd0, 16'h0040)); // Never taken
		repeat (N_BR - 2) issue(gen_branch());
		finish_test();

		cur_test = 6;
		issue(enc_i(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0005));
		issue(enc_r(mips_pkg::F_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
		issue(enc_i(mips_pkg::OP_LW, 5'd0, 5'd0, 16'h0004));
		issue(enc_r(mips_pkg::F_OR, 5'd0, 5'd0, 5'd3, 5'd0)); // r0 still zero
		issue(32'hfc00_0000); // Opcode 0x3f
		issue(enc_r(6'h01, 5'd1, 5'd2, 5'd3, 5'd0)); // Unknown function
		issue(enc_i(mips_pkg::OP_REGIMM, 5'd1, 5'h02, 16'h0004)); // Unknown rt code
		issue(enc_r(mips_pkg::F_JALR, 5'd1, 5'd0, 5'd0, 5'd0)); // Link to r0 dropped
		issue(enc_r(mips_pkg::F_ADDU, 5'd0, 5'd0, 5'd4, 5'd0));
		finish_test();

		for (int t = 0; t < N_TESTS; t++) begin
			if (fails[t] == 0)
				npass++;
		end
		$display("Tests passed: %0d, tests failed: %0d", npass, N_TESTS - npass);
		if (npass == N_TESTS)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+design
design/mips_pkg.sv
design/reg_file.sv
design/main_decode.sv
design/execute_stage.sv
design/result_stage.sv
design/mips_exec_top.sv
test/tb_mips_exec.sv

// File: Bender.yml
package:
  name: mips_exec

sources:
  - include_dirs:
      - design
    files:
      - design/mips_pkg.sv
      - design/reg_file.sv
      - design/main_decode.sv
      - design/execute_stage.sv
      - design/result_stage.sv
      - design/mips_exec_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_mips_exec.sv
